//--- src/prbs_consts.svh
`ifndef PRBS_CONSTS_SVH
`define PRBS_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath sizes

`define PRBS_WIDTH       32
`define PRBS_NUM_LANES   4
`define PRBS_FCNT_WIDTH  16

// Replaces an all-zero LFSR state
`define PRBS_RESTART     32'hffff_fffe

//////////////////////////////////////////////////////////////////////
// Frame markers, one per polynomial length

`define PRBS_MARK7       7'h12
`define PRBS_MARK15      15'h1234
`define PRBS_MARK23      23'h123456
`define PRBS_MARK31      31'h12345678

// Octet marker for count and fixed modes
`define PRBS_MARK_OCT    8'h12

`endif

//--- src/prbs_pkg.sv
`include "prbs_consts.svh"

package prbs_pkg;

    // Lane pattern mode, codes 6 and 7 fall back to fixed
    typedef enum logic [2:0] {
        MODE_PRBS7  = 3'd0,
        MODE_PRBS15 = 3'd1,
        MODE_PRBS23 = 3'd2,
        MODE_PRBS31 = 3'd3,
        MODE_CNT    = 3'd4,
        MODE_FIX    = 3'd5
    } prbs_mode_e;

    // One of the lanes
    typedef logic [$clog2(`PRBS_NUM_LANES)-1:0] lane_idx_t;

endpackage

//--- src/prbs_lfsr_octet.sv
`timescale 1ns/1ps
`include "prbs_consts.svh"

module prbs_lfsr_octet #(
    parameter int LEN = 7,
    parameter int TAP = 6
) (
    input  logic [`PRBS_WIDTH-1:0] din,
    output logic [`PRBS_WIDTH-1:0] dout
);

    logic [`PRBS_WIDTH-1:0] word;

    // Eight LFSR bits, oldest first, shifted in at the low end
    // Feedback taps read the running word so later bits see earlier ones
    always_comb begin
        word = din;
        for (int i = 0; i < 8; i++) begin
            word = {word[`PRBS_WIDTH-2:0], word[LEN-1] ^ word[TAP-1]};
        end
        dout = word;
    end

endmodule

//--- src/prbs_octet_step.sv
`timescale 1ns/1ps
`include "prbs_consts.svh"

module prbs_octet_step (
    input  logic [`PRBS_WIDTH-1:0] state,
    input  prbs_pkg::prbs_mode_e   mode,
    input  logic [1:0]             nob,
    output logic [`PRBS_WIDTH-1:0] next_state,
    output logic                   end_frame
);

    // Candidates indexed by octet count minus one
    logic [`PRBS_WIDTH-1:0] prbs_cand [4][4];
    logic [`PRBS_WIDTH-1:0] cnt_cand [4];
    logic [7:0]             cnt_oct [4];
    logic [`PRBS_WIDTH-1:0] fix_word;
    logic [`PRBS_WIDTH-1:0] step_word;
    logic [1:0]             oct_idx;
    logic                   oct_hit;

    // nob of 0 means four octets, so this wraps to index 3
    assign oct_idx = nob - 2'd1;

    //////////////////////////////////////////////////////////////////////
    // PRBS chains, one per polynomial

    for (genvar m = 0; m < 4; m++) begin : g_poly
        localparam int LEN = (m == 0) ? 7 : (m == 1) ? 15 : (m == 2) ? 23 : 31;
        localparam int TAP = (m == 0) ? 6 : (m == 1) ? 14 : (m == 2) ? 18 : 28;

        for (genvar o = 0; o < 4; o++) begin : g_oct
            if (o == 0) begin : g_first
                prbs_lfsr_octet #(.LEN(LEN), .TAP(TAP)) u_oct (
                    .din  (state),
                    .dout (prbs_cand[m][0])
                );
            end else begin : g_next
                prbs_lfsr_octet #(.LEN(LEN), .TAP(TAP)) u_oct (
                    .din  (prbs_cand[m][o-1]),
                    .dout (prbs_cand[m][o])
                );
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Count and fixed patterns

    // Oldest octet lands highest
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            cnt_oct[k] = state[7:0] + 8'(k + 1);
        end
        cnt_cand[0] = {state[23:0], cnt_oct[0]};
        cnt_cand[1] = {state[15:0], cnt_oct[0], cnt_oct[1]};
        cnt_cand[2] = {state[7:0], cnt_oct[0], cnt_oct[1], cnt_oct[2]};
        cnt_cand[3] = {cnt_oct[0], cnt_oct[1], cnt_oct[2], cnt_oct[3]};
    end

    assign fix_word = {4{state[7:0]}};

    //////////////////////////////////////////////////////////////////////
    // Mode select and restart

    always_comb begin
        case (mode)
            prbs_pkg::MODE_PRBS7:  step_word = prbs_cand[0][oct_idx];
            prbs_pkg::MODE_PRBS15: step_word = prbs_cand[1][oct_idx];
            prbs_pkg::MODE_PRBS23: step_word = prbs_cand[2][oct_idx];
            prbs_pkg::MODE_PRBS31: step_word = prbs_cand[3][oct_idx];
            prbs_pkg::MODE_CNT:    step_word = cnt_cand[oct_idx];
            default:               step_word = fix_word;
        endcase

        // Count mode is allowed to run from zero
        if (state == '0 && mode != prbs_pkg::MODE_CNT) begin
            next_state = `PRBS_RESTART;
        end else begin
            next_state = step_word;
        end
    end

    // New octets sit in the low nob bytes of the result
    always_comb begin
        oct_hit = 1'b0;
        for (int k = 0; k < 4; k++) begin
            if (k <= int'(oct_idx) && next_state[8*k +: 8] == `PRBS_MARK_OCT) begin
                oct_hit = 1'b1;
            end
        end
    end

    // PRBS markers match the pre-step state
    always_comb begin
        case (mode)
            prbs_pkg::MODE_PRBS7:  end_frame = (state[6:0] == `PRBS_MARK7);
            prbs_pkg::MODE_PRBS15: end_frame = (state[14:0] == `PRBS_MARK15);
            prbs_pkg::MODE_PRBS23: end_frame = (state[22:0] == `PRBS_MARK23);
            prbs_pkg::MODE_PRBS31: end_frame = (state[30:0] == `PRBS_MARK31);
            default:               end_frame = oct_hit;
        endcase
    end

endmodule

//--- src/prbs_lane.sv
`timescale 1ns/1ps
`include "prbs_consts.svh"

module prbs_lane (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   load,
    input  logic [`PRBS_WIDTH-1:0] seed,
    input  logic                   step,
    input  prbs_pkg::prbs_mode_e   mode,
    input  logic [1:0]             nob,
    output logic [`PRBS_WIDTH-1:0] data,
    output logic                   end_frame
);

    logic [`PRBS_WIDTH-1:0] next_word;
    logic                   step_eof;

    // Next word computed from the current lane state
    prbs_octet_step u_step (
        .state      (data),
        .mode       (mode),
        .nob        (nob),
        .next_state (next_word),
        .end_frame  (step_eof)
    );

    //////////////////////////////////////////////////////////////////////
    // Lane state

    // Seed load takes priority over a step
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data <= '0;
        end else if (load) begin
            data <= seed;
        end else if (step) begin
            data <= next_word;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Frame pulse

    // High for one cycle per marked step, cleared on idle or load
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            end_frame <= 1'b0;
        end else begin
            end_frame <= step && !load && step_eof;
        end
    end

endmodule

//--- src/prbs_lane_ctrl.sv
`timescale 1ns/1ps
`include "prbs_consts.svh"

module prbs_lane_ctrl (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      cfg_we,
    input  prbs_pkg::lane_idx_t       cfg_lane,
    input  prbs_pkg::prbs_mode_e      cfg_mode,
    input  logic [1:0]                cfg_nob,
    input  logic                      cfg_en,
    input  logic [`PRBS_WIDTH-1:0]    cfg_seed,
    input  logic                      run,
    output prbs_pkg::prbs_mode_e      lane_mode [`PRBS_NUM_LANES],
    output logic [1:0]                lane_nob [`PRBS_NUM_LANES],
    output logic [`PRBS_NUM_LANES-1:0] lane_load,
    output logic [`PRBS_WIDTH-1:0]    lane_seed [`PRBS_NUM_LANES],
    output logic [`PRBS_NUM_LANES-1:0] lane_step
);

    logic [`PRBS_NUM_LANES-1:0] lane_en;

    //////////////////////////////////////////////////////////////////////
    // Per-lane configuration

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `PRBS_NUM_LANES; i++) begin
                lane_mode[i] <= prbs_pkg::MODE_PRBS7;
                lane_nob[i]  <= 2'd1;
            end
            lane_en   <= '0;
            lane_load <= '0;
        end else begin
            // Load is a single-cycle pulse following the write
            lane_load <= '0;
            if (cfg_we) begin
                lane_mode[cfg_lane] <= cfg_mode;
                lane_nob[cfg_lane]  <= cfg_nob;
                lane_en[cfg_lane]   <= cfg_en;
                lane_load[cfg_lane] <= 1'b1;
            end
        end
    end

    // Seed held alongside the load pulse
    always_ff @(posedge clk) begin
        if (cfg_we) begin
            lane_seed[cfg_lane] <= cfg_seed;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Step enables

    // Lags run by one cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lane_step <= '0;
        end else begin
            lane_step <= lane_en & {`PRBS_NUM_LANES{run}};
        end
    end

endmodule

//--- src/prbs_frame_collect.sv
`timescale 1ns/1ps
`include "prbs_consts.svh"

module prbs_frame_collect (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [`PRBS_NUM_LANES-1:0]  end_frame,
    input  prbs_pkg::lane_idx_t         rd_lane,
    output logic [`PRBS_FCNT_WIDTH-1:0] frame_count
);

    logic [`PRBS_FCNT_WIDTH-1:0] cnt [`PRBS_NUM_LANES];

    //////////////////////////////////////////////////////////////////////
    // Frame counters

    // Saturate instead of wrapping
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `PRBS_NUM_LANES; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `PRBS_NUM_LANES; i++) begin
                if (end_frame[i] && cnt[i] != '1) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    // Readout
    assign frame_count = cnt[rd_lane];

endmodule

//--- src/prbs_gen_top.sv
`timescale 1ns/1ps
`include "prbs_consts.svh"

module prbs_gen_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        cfg_we,
    input  prbs_pkg::lane_idx_t         cfg_lane,
    input  prbs_pkg::prbs_mode_e        cfg_mode,
    input  logic [1:0]                  cfg_nob,
    input  logic                        cfg_en,
    input  logic [`PRBS_WIDTH-1:0]      cfg_seed,
    input  logic                        run,
    input  prbs_pkg::lane_idx_t         rd_lane,
    output logic [`PRBS_WIDTH-1:0]      lane_data [`PRBS_NUM_LANES],
    output logic [`PRBS_FCNT_WIDTH-1:0] frame_count
);

    prbs_pkg::prbs_mode_e       lane_mode [`PRBS_NUM_LANES];
    logic [1:0]                 lane_nob [`PRBS_NUM_LANES];
    logic [`PRBS_WIDTH-1:0]     lane_seed [`PRBS_NUM_LANES];
    logic [`PRBS_NUM_LANES-1:0] lane_load;
    logic [`PRBS_NUM_LANES-1:0] lane_step;
    logic [`PRBS_NUM_LANES-1:0] lane_end_frame;

    //////////////////////////////////////////////////////////////////////
    // Configuration

    prbs_lane_ctrl u_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .cfg_we    (cfg_we),
        .cfg_lane  (cfg_lane),
        .cfg_mode  (cfg_mode),
        .cfg_nob   (cfg_nob),
        .cfg_en    (cfg_en),
        .cfg_seed  (cfg_seed),
        .run       (run),
        .lane_mode (lane_mode),
        .lane_nob  (lane_nob),
        .lane_load (lane_load),
        .lane_seed (lane_seed),
        .lane_step (lane_step)
    );

    //////////////////////////////////////////////////////////////////////
    // Lanes

    for (genvar i = 0; i < `PRBS_NUM_LANES; i++) begin : g_lane
        prbs_lane u_lane (
            .clk       (clk),
            .arst_n    (arst_n),
            .load      (lane_load[i]),
            .seed      (lane_seed[i]),
            .step      (lane_step[i]),
            .mode      (lane_mode[i]),
            .nob       (lane_nob[i]),
            .data      (lane_data[i]),
            .end_frame (lane_end_frame[i])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Frame statistics

    prbs_frame_collect u_collect (
        .clk         (clk),
        .arst_n      (arst_n),
        .end_frame   (lane_end_frame),
        .rd_lane     (rd_lane),
        .frame_count (frame_count)
    );

endmodule

//--- test/prbs_gen_props.sv
`timescale 1ns/1ps
`include "prbs_consts.svh"

module prbs_gen_props (
    input logic                       clk,
    input logic                       arst_n,
    input logic [`PRBS_NUM_LANES-1:0] lane_load,
    input logic [`PRBS_NUM_LANES-1:0] lane_step,
    input logic [`PRBS_NUM_LANES-1:0] lane_end_frame,
    input logic [`PRBS_WIDTH-1:0]     lane_data [`PRBS_NUM_LANES]
);

    int fail_count = 0;

    for (genvar i = 0; i < `PRBS_NUM_LANES; i++) begin : g_lane
        // Seed load is a single-cycle pulse
        a_load_pulse: assert property (@(posedge clk) disable iff (!arst_n)
            lane_load[i] |=> !lane_load[i])
            else begin
                fail_count++;
                $error("lane %0d load held past one cycle", i);
            end

        // Idle lane keeps its word
        a_data_hold: assert property (@(posedge clk) disable iff (!arst_n)
            (!lane_load[i] && !lane_step[i]) |=> $stable(lane_data[i]))
            else begin
                fail_count++;
                $error("lane %0d data moved while idle", i);
            end

        a_frame_step: assert property (@(posedge clk) disable iff (!arst_n)
            lane_end_frame[i] |-> $past(lane_step[i]))
            else begin
                fail_count++;
                $error("lane %0d frame pulse without a step", i);
            end
    end

endmodule

bind prbs_gen_top prbs_gen_props u_props (
    .clk            (clk),
    .arst_n         (arst_n),
    .lane_load      (lane_load),
    .lane_step      (lane_step),
    .lane_end_frame (lane_end_frame),
    .lane_data      (lane_data)
);

//--- test/tb_prbs_gen.sv
`timescale 1ns/1ps
`include "prbs_consts.svh"

module tb_prbs_gen;

    logic                        clk;
    logic                        arst_n;
    logic                        cfg_we;
    prbs_pkg::lane_idx_t         cfg_lane;
    prbs_pkg::prbs_mode_e        cfg_mode;
    logic [1:0]                  cfg_nob;
    logic                        cfg_en;
    logic [`PRBS_WIDTH-1:0]      cfg_seed;
    logic                        run;
    prbs_pkg::lane_idx_t         rd_lane;
    logic [`PRBS_WIDTH-1:0]      lane_data [`PRBS_NUM_LANES];
    logic [`PRBS_FCNT_WIDTH-1:0] frame_count;

    // Lane model state
    prbs_pkg::prbs_mode_e        m_mode [`PRBS_NUM_LANES];
    logic [1:0]                  m_nob [`PRBS_NUM_LANES];
    logic                        m_en [`PRBS_NUM_LANES];
    logic                        m_load [`PRBS_NUM_LANES];
    logic                        m_step [`PRBS_NUM_LANES];
    logic                        m_eof [`PRBS_NUM_LANES];
    logic [`PRBS_WIDTH-1:0]      m_seed [`PRBS_NUM_LANES];
    logic [`PRBS_WIDTH-1:0]      m_state [`PRBS_NUM_LANES];
    logic [`PRBS_FCNT_WIDTH-1:0] m_cnt [`PRBS_NUM_LANES];

    prbs_gen_top u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .cfg_we      (cfg_we),
        .cfg_lane    (cfg_lane),
        .cfg_mode    (cfg_mode),
        .cfg_nob     (cfg_nob),
        .cfg_en      (cfg_en),
        .cfg_seed    (cfg_seed),
        .run         (run),
        .rd_lane     (rd_lane),
        .lane_data   (lane_data),
        .frame_count (frame_count)
    );

    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Reference model

    // Returns {end_frame, next word}
    function automatic logic [`PRBS_WIDTH:0] ref_step(input logic [`PRBS_WIDTH-1:0] s,
            input prbs_pkg::prbs_mode_e mode, input logic [1:0] nob);
        int                     n;
        int                     len;
        int                     tap;
        logic [`PRBS_WIDTH-1:0] w;
        logic [`PRBS_WIDTH-1:0] mark;
        logic [7:0]             oct;
        logic                   eof;
        n = (nob == 2'd0) ? 4 : int'(nob);
        w = s;
        eof = 1'b0;
        len = 0;
        tap = 0;
        mark = '0;
        case (mode)
            prbs_pkg::MODE_PRBS7: begin
                len = 7;
                tap = 6;
                mark = 32'(`PRBS_MARK7);
            end
            prbs_pkg::MODE_PRBS15: begin
                len = 15;
                tap = 14;
                mark = 32'(`PRBS_MARK15);
            end
            prbs_pkg::MODE_PRBS23: begin
                len = 23;
                tap = 18;
                mark = 32'(`PRBS_MARK23);
            end
            prbs_pkg::MODE_PRBS31: begin
                len = 31;
                tap = 28;
                mark = 32'(`PRBS_MARK31);
            end
            default: ;
        endcase
        if (len != 0) begin
            eof = ((s & ((32'd1 << len) - 32'd1)) == mark);
            for (int k = 0; k < 8 * n; k++) begin
                w = {w[`PRBS_WIDTH-2:0], w[len-1] ^ w[tap-1]};
            end
        end else if (mode == prbs_pkg::MODE_CNT) begin
            for (int k = 1; k <= n; k++) begin
                oct = s[7:0] + 8'(k);
                w = {w[`PRBS_WIDTH-9:0], oct};
                if (oct == `PRBS_MARK_OCT) begin
                    eof = 1'b1;
                end
            end
        end else begin
            w = {4{s[7:0]}};
            eof = (s[7:0] == `PRBS_MARK_OCT);
        end
        // All-zero state restarts, count mode excepted
        if (s == '0 && mode != prbs_pkg::MODE_CNT) begin
            w = `PRBS_RESTART;
        end
        return {eof, w};
    endfunction

    // Config register, load pulse, step enable and lane pipeline per edge
    always @(posedge clk or negedge arst_n) begin
        logic [`PRBS_WIDTH:0] res;
        if (!arst_n) begin
            for (int i = 0; i < `PRBS_NUM_LANES; i++) begin
                m_mode[i] = prbs_pkg::MODE_PRBS7;
                m_nob[i] = 2'd1;
                m_en[i] = 1'b0;
                m_load[i] = 1'b0;
                m_step[i] = 1'b0;
                m_eof[i] = 1'b0;
                m_seed[i] = '0;
                m_state[i] = '0;
                m_cnt[i] = '0;
            end
        end else begin
            for (int i = 0; i < `PRBS_NUM_LANES; i++) begin
                res = ref_step(m_state[i], m_mode[i], m_nob[i]);
                if (m_eof[i] && m_cnt[i] != '1) begin
                    m_cnt[i] = m_cnt[i] + 16'd1;
                end
                m_eof[i] = m_step[i] && !m_load[i] && res[`PRBS_WIDTH];
                if (m_load[i]) begin
                    m_state[i] = m_seed[i];
                end else if (m_step[i]) begin
                    m_state[i] = res[`PRBS_WIDTH-1:0];
                end
                m_step[i] = m_en[i] && run;
                m_load[i] = cfg_we && (int'(cfg_lane) == i);
                if (m_load[i]) begin
                    m_mode[i] = cfg_mode;
                    m_nob[i] = cfg_nob;
                    m_en[i] = cfg_en;
                    m_seed[i] = cfg_seed;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks

    task automatic check_word(input logic [`PRBS_WIDTH-1:0] got,
            input logic [`PRBS_WIDTH-1:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_count(input logic [`PRBS_FCNT_WIDTH-1:0] got,
            input logic [`PRBS_FCNT_WIDTH-1:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "count mismatch");
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (arst_n) begin
            for (int i = 0; i < `PRBS_NUM_LANES; i++) begin
                check_word(lane_data[i], m_state[i], $sformatf("lane %0d data", i));
            end
            check_count(frame_count, m_cnt[rd_lane], $sformatf("frame count %0d", rd_lane));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_lane_word(input int lane, input logic [`PRBS_WIDTH-1:0] value,
            input int limit);
        int cycles;
        cycles = 0;
        while (lane_data[lane] !== value) begin
            if (cycles == limit) begin
                $display("Lane %0d never showed %h within %0d cycles", lane, value, limit);
                $display("TESTBENCH FAILED");
                $fatal(1, "wait for lane word timed out");
            end
            tick();
            cycles++;
        end
    endtask

    task automatic wait_lane_change(input int lane, input logic [`PRBS_WIDTH-1:0] old,
            input int limit);
        int cycles;
        cycles = 0;
        while (lane_data[lane] === old) begin
            if (cycles == limit) begin
                $display("Lane %0d stayed at %h for %0d cycles", lane, old, limit);
                $display("TESTBENCH FAILED");
                $fatal(1, "wait for lane step timed out");
            end
            tick();
            cycles++;
        end
    endtask

    // Only called with run low, so the seed shows up and stays
    task automatic write_cfg(input int lane, input prbs_pkg::prbs_mode_e mode,
            input logic [1:0] nob, input logic en, input logic [`PRBS_WIDTH-1:0] seed);
        cfg_lane = prbs_pkg::lane_idx_t'(lane);
        cfg_mode = mode;
        cfg_nob = nob;
        cfg_en = en;
        cfg_seed = seed;
        cfg_we = 1'b1;
        tick();
        cfg_we = 1'b0;
        wait_lane_word(lane, seed, 4);
        tick();
    endtask

    // Readout walks across the lanes while running
    task automatic run_steps(input int n);
        run = 1'b1;
        for (int k = 0; k < n; k++) begin
            rd_lane = prbs_pkg::lane_idx_t'(rd_lane + 2'd1);
            tick();
        end
        run = 1'b0;
        tick();
        tick();
    endtask

    function automatic logic [`PRBS_WIDTH-1:0] random_seed();
        logic [`PRBS_WIDTH-1:0] v;
        v = $urandom;
        if (v == '0) begin
            v = 32'd1;
        end
        return v;
    endfunction

    initial begin
        logic [`PRBS_FCNT_WIDTH-1:0] held_cnt;
        clk = 1'b0;
        arst_n = 1'b0;
        cfg_we = 1'b0;
        cfg_lane = '0;
        cfg_mode = prbs_pkg::MODE_PRBS7;
        cfg_nob = 2'd1;
        cfg_en = 1'b0;
        cfg_seed = '0;
        run = 1'b0;
        rd_lane = '0;
        void'($urandom(32'ha2df));
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        tick();

        // All four polynomials side by side, for each octet count
        for (int nb = 0; nb < 4; nb++) begin
            for (int l = 0; l < `PRBS_NUM_LANES; l++) begin
                write_cfg(l, prbs_pkg::prbs_mode_e'(3'(l)), 2'(nb), 1'b1, random_seed());
            end
            run_steps(200);
        end

        // Seeds sitting on each polynomial's marker, top bit outside the compare
        write_cfg(0, prbs_pkg::MODE_PRBS7, 2'd1, 1'b1, 32'h8000_0000 | 32'(`PRBS_MARK7));
        write_cfg(1, prbs_pkg::MODE_PRBS15, 2'd2, 1'b1, 32'h8000_0000 | 32'(`PRBS_MARK15));
        write_cfg(2, prbs_pkg::MODE_PRBS23, 2'd3, 1'b1, 32'h8000_0000 | 32'(`PRBS_MARK23));
        write_cfg(3, prbs_pkg::MODE_PRBS31, 2'd0, 1'b1, 32'h8000_0000 | 32'(`PRBS_MARK31));
        run_steps(20);

        // Zero seeds
        write_cfg(0, prbs_pkg::MODE_PRBS23, 2'd2, 1'b1, '0);
        write_cfg(1, prbs_pkg::MODE_FIX, 2'd1, 1'b1, '0);
        write_cfg(2, prbs_pkg::MODE_CNT, 2'd1, 1'b1, '0);
        write_cfg(3, prbs_pkg::MODE_PRBS7, 2'd0, 1'b1, '0);
        run = 1'b1;
        wait_lane_change(0, '0, 8);
        run = 1'b0;
        check_word(lane_data[0], `PRBS_RESTART, "zero seed restart");
        check_word(lane_data[1], `PRBS_RESTART, "zero seed fixed restart");
        check_word(lane_data[2], 32'h0000_0001, "zero seed count");
        run_steps(10);

        // Count mode around the marker octet
        write_cfg(0, prbs_pkg::MODE_CNT, 2'd1, 1'b1, 32'h0000_000c);
        write_cfg(1, prbs_pkg::MODE_CNT, 2'd0, 1'b1, 32'h0000_000e);
        write_cfg(2, prbs_pkg::MODE_CNT, 2'd2, 1'b1, 32'h0000_0010);
        write_cfg(3, prbs_pkg::MODE_CNT, 2'd3, 1'b1, 32'h0000_ff0a);
        run_steps(600);

        // Fixed mode, codes 6 and 7 included
        write_cfg(0, prbs_pkg::MODE_FIX, 2'd1, 1'b1, 32'hdead_beef);
        write_cfg(1, prbs_pkg::prbs_mode_e'(3'd6), 2'd3, 1'b1, 32'h3456_7812);
        write_cfg(2, prbs_pkg::prbs_mode_e'(3'd7), 2'd0, 1'b1, 32'h0000_00a5);
        run_steps(30);
        check_word(lane_data[0], 32'hefef_efef, "fixed word");
        check_word(lane_data[1], 32'h1212_1212, "fixed word code 6");

        // Run low, then one lane disabled
        for (int l = 0; l < `PRBS_NUM_LANES; l++) begin
            write_cfg(l, prbs_pkg::MODE_PRBS15, 2'd2, 1'b1, random_seed());
        end
        repeat (20) tick();
        write_cfg(2, prbs_pkg::MODE_FIX, 2'd1, 1'b0, 32'h0000_0012);
        rd_lane = 2'd2;
        tick();
        held_cnt = m_cnt[2];
        run_steps(50);
        rd_lane = 2'd2;
        tick();
        check_word(lane_data[2], 32'h0000_0012, "disabled lane data");
        check_count(frame_count, held_cnt, "disabled lane count");

        // Mixed lanes running together
        write_cfg(0, prbs_pkg::MODE_PRBS31, 2'd3, 1'b1, random_seed());
        write_cfg(1, prbs_pkg::MODE_CNT, 2'd2, 1'b1, 32'h0000_000e);
        write_cfg(2, prbs_pkg::MODE_FIX, 2'd1, 1'b1, 32'h0000_0012);
        write_cfg(3, prbs_pkg::MODE_PRBS7, 2'd0, 1'b1, random_seed());
        run_steps(300);

        if (u_dut.u_props.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+src
src/prbs_pkg.sv
src/prbs_lfsr_octet.sv
src/prbs_octet_step.sv
src/prbs_lane.sv
src/prbs_lane_ctrl.sv
src/prbs_frame_collect.sv
src/prbs_gen_top.sv
test/prbs_gen_props.sv
test/tb_prbs_gen.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := tb_prbs_gen
FILELIST   := src.f
BUILD_DIR  := obj_dir
PASS_MSG   := TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
